/* common/cluster_periph_pkg.sv */
// ********************
// shared bus structs, event layout and register map of the cluster peripherals
// only address bits [7:0] are decoded by the slaves
// ********************
package cluster_periph_pkg;

  localparam int unsigned PER_ADDR_W = 32;
  localparam int unsigned PER_DATA_W = 32;
  localparam int unsigned PER_ID_W   = 5;

  // plain req/gnt/r_valid bus, wen low means write
  typedef struct packed {
    logic                  req;
    logic [PER_ADDR_W-1:0] add;
    logic                  wen;
    logic [PER_DATA_W-1:0] wdata;
    logic [3:0]            be;
    logic [PER_ID_W-1:0]   id;
  } periph_req_t;

  typedef struct packed {
    logic                  gnt;
    logic                  r_valid;
    logic [PER_DATA_W-1:0] r_rdata;
    logic [PER_ID_W-1:0]   r_id;
  } periph_rsp_t;

  // per-core event lines
  localparam int unsigned EVT_NUM     = 7;
  localparam int unsigned EVT_ACC_LSB = 0;
  localparam int unsigned EVT_DMA     = 4;
  localparam int unsigned EVT_DMA_IRQ = 5;
  localparam int unsigned EVT_TIMER   = 6;

  typedef logic [EVT_NUM-1:0] evt_vec_t;
  typedef logic [4:0]         irq_id_t;

  // slave port indices, the event unit owns two plugs
  localparam int unsigned NB_SPERIPHS     = 4;
  localparam int unsigned SPER_EOC_ID     = 0;
  localparam int unsigned SPER_TIMER_ID   = 1;
  localparam int unsigned SPER_EVENT_U_ID = 2;

  // register offsets
  localparam logic [7:0] CU_EOC          = 8'h00;
  localparam logic [7:0] CU_FETCH_EN     = 8'h08;
  localparam logic [7:0] CU_BOOT_BASE    = 8'h40;
  localparam logic [7:0] TIM_CFG         = 8'h00;
  localparam logic [7:0] TIM_CNT         = 8'h08;
  localparam logic [7:0] TIM_CMP         = 8'h10;
  localparam logic [7:0] EU_MASK_BASE    = 8'h00;
  localparam logic [7:0] EU_BUFFER_BASE  = 8'h40;
  localparam logic [7:0] EU_BUF_CLR_BASE = 8'h80;

endpackage

/* control_unit/cluster_control_unit.sv */
// ********************
// eoc, fetch enable and boot address registers, full-word writes only
// byte enables are not honoured
// ********************
`timescale 1ns/1ps

module cluster_control_unit
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES  = 4,
  parameter logic [31:0] BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  periph_req_t               req_i,
  output periph_rsp_t               rsp_o,
  output logic                      eoc_o,
  output logic [NB_CORES-1:0]       fetch_enable_o,
  output logic [NB_CORES-1:0][31:0] boot_addr_o
);

  logic [7:0]            offs;
  logic                  wr_en;
  logic [PER_DATA_W-1:0] rdata_d;
  logic                  r_valid_q;
  logic [PER_ID_W-1:0]   r_id_q;
  logic [PER_DATA_W-1:0] r_rdata_q;

  assign offs  = req_i.add[7:0];
  assign wr_en = req_i.req & ~req_i.wen;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_o          <= 1'b0;
      fetch_enable_o <= '0;
      boot_addr_o    <= {NB_CORES{BOOT_ADDR}};
    end else if (wr_en) begin
      if (offs == CU_EOC) begin
        eoc_o <= req_i.wdata[0];
      end
      if (offs == CU_FETCH_EN) begin
        fetch_enable_o <= req_i.wdata[NB_CORES-1:0];
      end
      for (int c = 0; c < NB_CORES; c++) begin
        if (offs == CU_BOOT_BASE + 8'(4 * c)) begin
          boot_addr_o[c] <= req_i.wdata;
        end
      end
    end
  end

  // read mux, unmapped offsets return zero
  always_comb begin
    rdata_d = '0;
    if (offs == CU_EOC) begin
      rdata_d[0] = eoc_o;
    end
    if (offs == CU_FETCH_EN) begin
      rdata_d[NB_CORES-1:0] = fetch_enable_o;
    end
    for (int c = 0; c < NB_CORES; c++) begin
      if (offs == CU_BOOT_BASE + 8'(4 * c)) begin
        rdata_d = boot_addr_o[c];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
    end
  end

  // response payload, write responses carry zero data
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_id_q    <= req_i.id;
      r_rdata_q <= req_i.wen ? rdata_d : '0;
    end
  end

  assign rsp_o = '{gnt: req_i.req, r_valid: r_valid_q, r_rdata: r_rdata_q, r_id: r_id_q};

endmodule

/* timer/cluster_timer.sv */
// ********************
// 32-bit cycle counter, wraps to zero on compare match
// evt_o is high the cycle after the match
// ********************
`timescale 1ns/1ps

module cluster_timer
  import cluster_periph_pkg::*;
(
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  periph_req_t req_i,
  output periph_rsp_t rsp_o,
  output logic        evt_o,
  output logic        busy_o
);

  logic [7:0]            offs;
  logic                  wr_en;
  logic                  en_q;
  logic [31:0]           cnt_q;
  logic [31:0]           cmp_q;
  logic [PER_DATA_W-1:0] rdata_d;
  logic                  r_valid_q;
  logic [PER_ID_W-1:0]   r_id_q;
  logic [PER_DATA_W-1:0] r_rdata_q;

  assign offs  = req_i.add[7:0];
  assign wr_en = req_i.req & ~req_i.wen;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q  <= 1'b0;
      cnt_q <= '0;
      cmp_q <= '1;
      evt_o <= 1'b0;
    end else begin
      // match pulse, delayed one cycle
      evt_o <= en_q && (cnt_q == cmp_q);
      if (wr_en && offs == TIM_CNT) begin
        cnt_q <= req_i.wdata;
      end else if (en_q) begin
        cnt_q <= (cnt_q == cmp_q) ? '0 : cnt_q + 32'd1;
      end
      if (wr_en && offs == TIM_CFG) begin
        en_q <= req_i.wdata[0];
      end
      if (wr_en && offs == TIM_CMP) begin
        cmp_q <= req_i.wdata;
      end
    end
  end

  always_comb begin
    unique case (offs)
      TIM_CFG: rdata_d = {31'd0, en_q};
      TIM_CNT: rdata_d = cnt_q;
      TIM_CMP: rdata_d = cmp_q;
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      r_id_q    <= req_i.id;
      r_rdata_q <= req_i.wen ? rdata_d : '0;
    end
  end

  assign busy_o = en_q;
  assign rsp_o  = '{gnt: req_i.req, r_valid: r_valid_q, r_rdata: r_rdata_q, r_id: r_id_q};

endmodule

/* event_unit/event_unit_irq.sv */
// ********************
// per-core event buffers and interrupt request
// a set in the same cycle as a clear wins
// ********************
`timescale 1ns/1ps

module event_unit_irq
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  evt_vec_t [NB_CORES-1:0]    events_i,
  input  evt_vec_t [NB_CORES-1:0]    mask_i,
  input  evt_vec_t [NB_CORES-1:0]    buf_clr_i,
  input  logic     [NB_CORES-1:0]    irq_ack_i,
  input  irq_id_t  [NB_CORES-1:0]    irq_ack_id_i,
  output evt_vec_t [NB_CORES-1:0]    buffer_o,
  output logic     [NB_CORES-1:0]    irq_req_o,
  output irq_id_t  [NB_CORES-1:0]    irq_id_o
);

  evt_vec_t [NB_CORES-1:0] ack_clr;
  evt_vec_t [NB_CORES-1:0] masked;

  // decode the acknowledged id into a clear mask
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      for (int b = 0; b < EVT_NUM; b++) begin
        ack_clr[c][b] = irq_ack_i[c] && (irq_ack_id_i[c] == irq_id_t'(b));
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buffer_o <= '0;
    end else begin
      for (int c = 0; c < NB_CORES; c++) begin
        buffer_o[c] <= (buffer_o[c] & ~(ack_clr[c] | buf_clr_i[c])) | events_i[c];
      end
    end
  end

  // lowest pending index has priority
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      masked[c]    = buffer_o[c] & mask_i[c];
      irq_req_o[c] = |masked[c];
      irq_id_o[c]  = '0;
      for (int b = EVT_NUM - 1; b >= 0; b--) begin
        if (masked[c][b]) begin
          irq_id_o[c] = irq_id_t'(b);
        end
      end
    end
  end

endmodule

/* event_unit/event_unit_regs.sv */
// ********************
// two plugs merged, plug 0 wins on collision
// holds the per-core masks and drives the buffer clear pulse
// ********************
`timescale 1ns/1ps

module event_unit_regs
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES = 4
) (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  periph_req_t [1:0]            plug_req_i,
  output periph_rsp_t [1:0]            plug_rsp_o,
  input  evt_vec_t    [NB_CORES-1:0]   buffer_i,
  output evt_vec_t    [NB_CORES-1:0]   mask_o,
  output evt_vec_t    [NB_CORES-1:0]   buf_clr_o
);

  logic                  sel_1;
  logic                  sel_q;
  periph_req_t           req_m;
  logic [7:0]            offs;
  logic                  wr_en;
  logic [PER_DATA_W-1:0] rdata_d;
  logic                  r_valid_q;
  logic [PER_ID_W-1:0]   r_id_q;
  logic [PER_DATA_W-1:0] r_rdata_q;

  // plug 1 only when it requests alone
  assign sel_1 = plug_req_i[1].req & ~plug_req_i[0].req;
  assign req_m = sel_1 ? plug_req_i[1] : plug_req_i[0];
  assign offs  = req_m.add[7:0];
  assign wr_en = req_m.req & ~req_m.wen;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mask_o <= '0;
    end else if (wr_en) begin
      for (int c = 0; c < NB_CORES; c++) begin
        if (offs == EU_MASK_BASE + 8'(4 * c)) begin
          mask_o[c] <= req_m.wdata[EVT_NUM-1:0];
        end
      end
    end
  end

  // clear bits act on the edge of the granted write
  always_comb begin
    rdata_d = '0;
    for (int c = 0; c < NB_CORES; c++) begin
      buf_clr_o[c] = '0;
      if (wr_en && offs == EU_BUF_CLR_BASE + 8'(4 * c)) begin
        buf_clr_o[c] = req_m.wdata[EVT_NUM-1:0];
      end
      if (offs == EU_MASK_BASE + 8'(4 * c)) begin
        rdata_d[EVT_NUM-1:0] = mask_o[c];
      end
      if (offs == EU_BUFFER_BASE + 8'(4 * c)) begin
        rdata_d[EVT_NUM-1:0] = buffer_i[c];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
      sel_q     <= 1'b0;
    end else begin
      r_valid_q <= req_m.req;
      sel_q     <= sel_1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_m.req) begin
      r_id_q    <= req_m.id;
      r_rdata_q <= req_m.wen ? rdata_d : '0;
    end
  end

  // response only towards the plug served last cycle
  always_comb begin
    plug_rsp_o                = '0;
    plug_rsp_o[0].gnt         = plug_req_i[0].req;
    plug_rsp_o[1].gnt         = sel_1;
    plug_rsp_o[sel_q].r_valid = r_valid_q;
    plug_rsp_o[sel_q].r_rdata = r_rdata_q;
    plug_rsp_o[sel_q].r_id    = r_id_q;
  end

endmodule

/* hdl/cluster_periph_top.sv */
// ********************
// cluster peripherals: control unit, timer and event unit on four slave ports
// ********************
`timescale 1ns/1ps

module cluster_periph_top
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES  = 4,
  parameter logic [31:0] BOOT_ADDR = 32'h1C00_0000
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  periph_req_t [NB_SPERIPHS-1:0]        speriph_req_i,
  output periph_rsp_t [NB_SPERIPHS-1:0]        speriph_rsp_o,
  input  logic        [NB_CORES-1:0][3:0]      hwpe_events_i,
  input  logic                                 dma_cl_event_i,
  input  logic                                 dma_cl_irq_i,
  output logic        [NB_CORES-1:0]           irq_req_o,
  output irq_id_t     [NB_CORES-1:0]           irq_id_o,
  input  logic        [NB_CORES-1:0]           irq_ack_i,
  input  irq_id_t     [NB_CORES-1:0]           irq_ack_id_i,
  output logic                                 eoc_o,
  output logic        [NB_CORES-1:0]           fetch_enable_o,
  output logic        [NB_CORES-1:0][31:0]     boot_addr_o,
  output logic                                 busy_o
);

  logic                          timer_evt;
  evt_vec_t [NB_CORES-1:0]       core_events;
  evt_vec_t [NB_CORES-1:0]       eu_mask;
  evt_vec_t [NB_CORES-1:0]       eu_buf_clr;
  evt_vec_t [NB_CORES-1:0]       eu_buffer;

  // dma and timer events are common, accelerator events are per core
  always_comb begin
    for (int c = 0; c < NB_CORES; c++) begin
      core_events[c]                     = '0;
      core_events[c][EVT_ACC_LSB +: 4]   = hwpe_events_i[c];
      core_events[c][EVT_DMA]            = dma_cl_event_i;
      core_events[c][EVT_DMA_IRQ]        = dma_cl_irq_i;
      core_events[c][EVT_TIMER]          = timer_evt;
    end
  end

  // ********************
  // control unit
  // ********************
  cluster_control_unit #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) i_control_unit (
    .clk_i          ( clk_i                       ),
    .arst_n_i       ( arst_n_i                    ),
    .req_i          ( speriph_req_i[SPER_EOC_ID]  ),
    .rsp_o          ( speriph_rsp_o[SPER_EOC_ID]  ),
    .eoc_o          ( eoc_o                       ),
    .fetch_enable_o ( fetch_enable_o              ),
    .boot_addr_o    ( boot_addr_o                 )
  );

  // ********************
  // timer
  // ********************
  cluster_timer i_timer (
    .clk_i    ( clk_i                         ),
    .arst_n_i ( arst_n_i                      ),
    .req_i    ( speriph_req_i[SPER_TIMER_ID]  ),
    .rsp_o    ( speriph_rsp_o[SPER_TIMER_ID]  ),
    .evt_o    ( timer_evt                     ),
    .busy_o   ( busy_o                        )
  );

  // ********************
  // event unit
  // ********************
  event_unit_regs #(
    .NB_CORES ( NB_CORES )
  ) i_eu_regs (
    .clk_i      ( clk_i                                ),
    .arst_n_i   ( arst_n_i                             ),
    .plug_req_i ( speriph_req_i[SPER_EVENT_U_ID +: 2]  ),
    .plug_rsp_o ( speriph_rsp_o[SPER_EVENT_U_ID +: 2]  ),
    .buffer_i   ( eu_buffer                            ),
    .mask_o     ( eu_mask                              ),
    .buf_clr_o  ( eu_buf_clr                           )
  );

  event_unit_irq #(
    .NB_CORES ( NB_CORES )
  ) i_eu_irq (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .events_i     ( core_events  ),
    .mask_i       ( eu_mask      ),
    .buf_clr_i    ( eu_buf_clr   ),
    .irq_ack_i    ( irq_ack_i    ),
    .irq_ack_id_i ( irq_ack_id_i ),
    .buffer_o     ( eu_buffer    ),
    .irq_req_o    ( irq_req_o    ),
    .irq_id_o     ( irq_id_o     )
  );

endmodule

/* verif/cluster_periph_checker.sv */
// ********************
// bus and interrupt rules, bound into cluster_periph_top
// ********************
`timescale 1ns/1ps

module cluster_periph_checker
  import cluster_periph_pkg::*;
#(
  parameter int unsigned NB_CORES = 4
) (
  input logic                          clk_i,
  input logic                          arst_n_i,
  input periph_req_t [NB_SPERIPHS-1:0] speriph_req_i,
  input periph_rsp_t [NB_SPERIPHS-1:0] speriph_rsp_o,
  input logic        [NB_CORES-1:0]    irq_req_o,
  input irq_id_t     [NB_CORES-1:0]    irq_id_o
);

  for (genvar p = 0; p < NB_SPERIPHS; p++) begin : g_port
    // a response follows a granted request by one cycle
    a_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      speriph_rsp_o[p].r_valid |-> $past(speriph_req_i[p].req && speriph_rsp_o[p].gnt))
      else $error("r_valid on port %0d without a grant in the previous cycle", p);
    a_rid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      speriph_rsp_o[p].r_valid |-> speriph_rsp_o[p].r_id == $past(speriph_req_i[p].id))
      else $error("r_id on port %0d differs from the granted request id", p);
  end

  for (genvar c = 0; c < NB_CORES; c++) begin : g_core
    a_irq_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      irq_req_o[c] |-> irq_id_o[c] < irq_id_t'(EVT_NUM))
      else $error("irq id out of range on core %0d", c);
  end

  // only one event unit plug is granted per cycle
  a_plug_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(speriph_rsp_o[SPER_EVENT_U_ID].gnt && speriph_rsp_o[SPER_EVENT_U_ID + 1].gnt))
    else $error("both event unit plugs granted in the same cycle");

endmodule

/* verif/tb_cluster_periph.sv */
// ********************
// directed tests of the cluster peripherals with NB_CORES of 4
// one transaction per port at a time
// only the plug merge test drives two plugs together
// ********************
`timescale 1ns/1ps

module tb_cluster_periph
  import cluster_periph_pkg::*;
();

  localparam int unsigned NB_CORES        = 4;
  localparam logic [31:0] BOOT_ADDR       = 32'h1C00_0000;
  localparam int          SEED            = 70300;
  localparam int          NUM_TESTS       = 6;
  localparam int          WATCHDOG_CYCLES = NUM_TESTS * 2000 + 100;
  localparam int          EU_PLUG0        = SPER_EVENT_U_ID;
  localparam int          EU_PLUG1        = SPER_EVENT_U_ID + 1;

  logic                                clk_i;
  logic                                arst_n_i;
  periph_req_t [NB_SPERIPHS-1:0]       speriph_req;
  periph_rsp_t [NB_SPERIPHS-1:0]       speriph_rsp;
  logic        [NB_CORES-1:0][3:0]     hwpe_events;
  logic                                dma_cl_event;
  logic                                dma_cl_irq;
  logic        [NB_CORES-1:0]          irq_req_o;
  irq_id_t     [NB_CORES-1:0]          irq_id_o;
  logic        [NB_CORES-1:0]          irq_ack;
  irq_id_t     [NB_CORES-1:0]          irq_ack_id;
  logic                                eoc_o;
  logic        [NB_CORES-1:0]          fetch_enable_o;
  logic        [NB_CORES-1:0][31:0]    boot_addr_o;
  logic                                busy_o;

  int                  errors;
  logic [PER_ID_W-1:0] next_id;

  cluster_periph_top #(
    .NB_CORES  ( NB_CORES  ),
    .BOOT_ADDR ( BOOT_ADDR )
  ) dut (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .speriph_req_i  ( speriph_req    ),
    .speriph_rsp_o  ( speriph_rsp    ),
    .hwpe_events_i  ( hwpe_events    ),
    .dma_cl_event_i ( dma_cl_event   ),
    .dma_cl_irq_i   ( dma_cl_irq     ),
    .irq_req_o      ( irq_req_o      ),
    .irq_id_o       ( irq_id_o       ),
    .irq_ack_i      ( irq_ack        ),
    .irq_ack_id_i   ( irq_ack_id     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .busy_o         ( busy_o         )
  );

  bind cluster_periph_top cluster_periph_checker #(
    .NB_CORES ( NB_CORES )
  ) i_checker (
    .clk_i         ( clk_i         ),
    .arst_n_i      ( arst_n_i      ),
    .speriph_req_i ( speriph_req_i ),
    .speriph_rsp_o ( speriph_rsp_o ),
    .irq_req_o     ( irq_req_o     ),
    .irq_id_o      ( irq_id_o      )
  );

  always #5 clk_i = ~clk_i;

  // ********************
  // compare tasks
  // ********************
  task automatic check_data(input string test, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, exp, act);
    end
  endtask

  task automatic check_irq_id(input string test, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected irq id %0d, actual %0d", test, exp, act);
    end
  endtask

  task automatic check_evt(input string test, input evt_vec_t exp, input evt_vec_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected events 0b%07b, actual 0b%07b", test, exp, act);
    end
  endtask

  // ********************
  // bus and event tasks
  // ********************
  // the request is held from a rising edge until granted and answered one cycle later
  task automatic bus_xfer(
    input  string       test,
    input  int          port,
    input  logic [7:0]  offs,
    input  logic        wr,
    input  logic [31:0] wdata,
    output logic [31:0] rdata,
    output int          waits
  );
    logic [PER_ID_W-1:0] id;
    id      = next_id;
    next_id = next_id + 5'd1;
    waits   = 0;
    @(posedge clk_i);
    speriph_req[port] <= '{req: 1'b1, add: {24'd0, offs}, wen: ~wr, wdata: wdata,
                           be: 4'hf, id: id};
    @(negedge clk_i);
    while (!speriph_rsp[port].gnt && waits < 16) begin
      waits++;
      @(negedge clk_i);
    end
    if (!speriph_rsp[port].gnt) begin
      errors++;
      $display("%s: no grant on port %0d after %0d cycles", test, port, waits);
    end
    @(posedge clk_i);
    speriph_req[port] <= '0;
    @(negedge clk_i);
    if (!speriph_rsp[port].r_valid) begin
      errors++;
      $display("%s: no r_valid on port %0d in the cycle after the grant", test, port);
    end else if (speriph_rsp[port].r_id !== id) begin
      errors++;
      $display("%s: r_id %0d on port %0d does not match request id %0d",
               test, speriph_rsp[port].r_id, port, id);
    end
    rdata = speriph_rsp[port].r_rdata;
  endtask

  task automatic bus_write(input string test, input int port, input logic [7:0] offs,
                           input logic [31:0] data);
    logic [31:0] rd;
    int          waits;
    bus_xfer(test, port, offs, 1'b1, data, rd, waits);
    // a lone request is granted in its own cycle
    check_data(test, 32'd0, 32'(waits));
    // write responses carry no data
    check_data(test, 32'd0, rd);
  endtask

  task automatic bus_read(input string test, input int port, input logic [7:0] offs,
                          output logic [31:0] data);
    int waits;
    bus_xfer(test, port, offs, 1'b0, 32'd0, data, waits);
    check_data(test, 32'd0, 32'(waits));
  endtask

  task automatic pulse_events(input int core, input logic [3:0] hwpe, input logic dma_evt,
                              input logic dma_irq);
    @(posedge clk_i);
    hwpe_events[core] <= hwpe;
    dma_cl_event      <= dma_evt;
    dma_cl_irq        <= dma_irq;
    @(posedge clk_i);
    hwpe_events  <= '0;
    dma_cl_event <= 1'b0;
    dma_cl_irq   <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic ack_irq(input int core, input irq_id_t id);
    @(posedge clk_i);
    irq_ack[core]    <= 1'b1;
    irq_ack_id[core] <= id;
    @(posedge clk_i);
    irq_ack <= '0;
    @(negedge clk_i);
  endtask

  task automatic clear_all_buffers(input string test);
    for (int c = 0; c < NB_CORES; c++) begin
      bus_write(test, EU_PLUG0, EU_BUF_CLR_BASE + 8'(4 * c), 32'h7f);
    end
  endtask

  // ********************
  // tests
  // ********************
  task automatic test_reset();
    for (int c = 0; c < NB_CORES; c++) begin
      check_data("reset", BOOT_ADDR, boot_addr_o[c]);
    end
    check_data("reset", 32'd0, 32'(eoc_o));
    check_data("reset", 32'd0, 32'(fetch_enable_o));
    check_data("reset", 32'd0, 32'(irq_req_o));
    check_data("reset", 32'd0, 32'(busy_o));
    for (int p = 0; p < NB_SPERIPHS; p++) begin
      check_data("reset", 32'd0, 32'({speriph_rsp[p].gnt, speriph_rsp[p].r_valid}));
    end
  endtask

  task automatic test_control_unit();
    logic [NB_CORES-1:0][31:0] exp_boot;
    logic [NB_CORES-1:0]       exp_fe;
    logic [31:0]               rd;
    for (int c = 0; c < NB_CORES; c++) begin
      exp_boot[c] = $urandom();
      bus_write("control_unit", SPER_EOC_ID, CU_BOOT_BASE + 8'(4 * c), exp_boot[c]);
    end
    exp_fe = NB_CORES'($urandom_range(15, 1));
    bus_write("control_unit", SPER_EOC_ID, CU_FETCH_EN, 32'(exp_fe));
    bus_write("control_unit", SPER_EOC_ID, CU_EOC, 32'd1);
    check_data("control_unit", 32'd1, 32'(eoc_o));
    check_data("control_unit", 32'(exp_fe), 32'(fetch_enable_o));
    for (int c = 0; c < NB_CORES; c++) begin
      check_data("control_unit", exp_boot[c], boot_addr_o[c]);
      bus_read("control_unit", SPER_EOC_ID, CU_BOOT_BASE + 8'(4 * c), rd);
      check_data("control_unit", exp_boot[c], rd);
    end
    bus_read("control_unit", SPER_EOC_ID, CU_FETCH_EN, rd);
    check_data("control_unit", 32'(exp_fe), rd);
    bus_read("control_unit", SPER_EOC_ID, CU_EOC, rd);
    check_data("control_unit", 32'd1, rd);
    // 0x24 is not mapped
    bus_write("control_unit", SPER_EOC_ID, 8'h24, $urandom());
    bus_read("control_unit", SPER_EOC_ID, 8'h24, rd);
    check_data("control_unit", 32'd0, rd);
    bus_write("control_unit", SPER_EOC_ID, CU_EOC, 32'd0);
    check_data("control_unit", 32'd0, 32'(eoc_o));
  endtask

  task automatic test_timer();
    logic [31:0] rd;
    int          cycles;
    bus_write("timer", SPER_TIMER_ID, TIM_CMP, 32'd20);
    bus_write("timer", EU_PLUG0, EU_MASK_BASE, 32'(1 << EVT_TIMER));
    bus_write("timer", SPER_TIMER_ID, TIM_CFG, 32'd1);
    check_data("timer", 32'd1, 32'(busy_o));
    cycles = 0;
    while (!irq_req_o[0] && cycles < 40) begin
      cycles++;
      @(negedge clk_i);
    end
    if (!irq_req_o[0]) begin
      errors++;
      $display("timer: no interrupt on core 0 within 40 cycles");
    end
    check_irq_id("timer", irq_id_t'(EVT_TIMER), irq_id_o[0]);
    bus_read("timer", SPER_TIMER_ID, TIM_CNT, rd);
    if (rd > 32'd20) begin
      errors++;
      $display("[ERROR] timer: expected TIM_CNT <= 20, actual %0d", rd);
    end
    bus_write("timer", SPER_TIMER_ID, TIM_CFG, 32'd0);
    check_data("timer", 32'd0, 32'(busy_o));
    bus_write("timer", EU_PLUG0, EU_MASK_BASE, 32'd0);
    clear_all_buffers("timer");
    check_data("timer", 32'd0, 32'(irq_req_o));
  endtask

  task automatic test_priority();
    bus_write("priority", EU_PLUG0, EU_MASK_BASE + 8'd4, 32'h7f);
    pulse_events(1, 4'b0100, 1'b0, 1'b1);
    check_data("priority", 32'd1, 32'(irq_req_o[1]));
    check_irq_id("priority", irq_id_t'(2), irq_id_o[1]);
    ack_irq(1, irq_id_t'(2));
    check_data("priority", 32'd1, 32'(irq_req_o[1]));
    check_irq_id("priority", irq_id_t'(EVT_DMA_IRQ), irq_id_o[1]);
    ack_irq(1, irq_id_t'(EVT_DMA_IRQ));
    check_data("priority", 32'd0, 32'(irq_req_o[1]));
    bus_write("priority", EU_PLUG0, EU_MASK_BASE + 8'd4, 32'd0);
    clear_all_buffers("priority");
  endtask

  task automatic test_mask_clear();
    evt_vec_t    exp_evt;
    logic [31:0] rd;
    exp_evt          = '0;
    exp_evt[EVT_DMA] = 1'b1;
    // core 2 keeps its mask at zero
    pulse_events(2, 4'b0000, 1'b1, 1'b0);
    check_data("mask_clear", 32'd0, 32'(irq_req_o[2]));
    bus_read("mask_clear", EU_PLUG0, EU_BUFFER_BASE + 8'd8, rd);
    check_evt("mask_clear", exp_evt, rd[EVT_NUM-1:0]);
    bus_write("mask_clear", EU_PLUG0, EU_BUF_CLR_BASE + 8'd8, 32'h7f);
    bus_read("mask_clear", EU_PLUG0, EU_BUFFER_BASE + 8'd8, rd);
    check_evt("mask_clear", '0, rd[EVT_NUM-1:0]);
    clear_all_buffers("mask_clear");
  endtask

  task automatic test_plug_merge();
    logic [31:0] rd2;
    logic [31:0] rd3;
    logic [31:0] val_a;
    logic [31:0] val_b;
    int          w2;
    int          w3;
    val_a = 32'($urandom_range(127, 1));
    val_b = 32'($urandom_range(127, 1));
    bus_write("plug_merge", EU_PLUG1, EU_MASK_BASE + 8'd12, val_a);
    bus_read("plug_merge", EU_PLUG1, EU_MASK_BASE + 8'd12, rd3);
    check_data("plug_merge", val_a, rd3);
    // both plugs request together and plug 3 is granted one cycle after plug 2
    fork
      bus_xfer("plug_merge", EU_PLUG0, EU_MASK_BASE, 1'b1, val_a, rd2, w2);
      bus_xfer("plug_merge", EU_PLUG1, EU_MASK_BASE + 8'd4, 1'b1, val_b, rd3, w3);
    join
    check_data("plug_merge", 32'd0, 32'(w2));
    check_data("plug_merge", 32'd1, 32'(w3));
    fork
      bus_xfer("plug_merge", EU_PLUG0, EU_MASK_BASE + 8'd4, 1'b0, 32'd0, rd2, w2);
      bus_xfer("plug_merge", EU_PLUG1, EU_MASK_BASE, 1'b0, 32'd0, rd3, w3);
    join
    check_data("plug_merge", 32'd0, 32'(w2));
    check_data("plug_merge", 32'd1, 32'(w3));
    check_data("plug_merge", val_b, rd2);
    check_data("plug_merge", val_a, rd3);
    for (int c = 0; c < NB_CORES; c++) begin
      bus_write("plug_merge", EU_PLUG0, EU_MASK_BASE + 8'(4 * c), 32'd0);
    end
  endtask

  // ********************
  // main sequence and watchdog
  // ********************
  initial begin
    void'($urandom(SEED));
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    speriph_req  = '0;
    hwpe_events  = '0;
    dma_cl_event = 1'b0;
    dma_cl_irq   = 1'b0;
    irq_ack      = '0;
    irq_ack_id   = '0;
    errors       = 0;
    next_id      = '0;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    test_reset();
    test_control_unit();
    test_timer();
    test_priority();
    test_mask_clear();
    test_plug_merge();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* vlog.f */
common/cluster_periph_pkg.sv
control_unit/cluster_control_unit.sv
timer/cluster_timer.sv
event_unit/event_unit_irq.sv
event_unit/event_unit_regs.sv
hdl/cluster_periph_top.sv
verif/cluster_periph_checker.sv
verif/tb_cluster_periph.sv

/* Makefile */
# Verilator build and run of the cluster peripheral testbench
SIM := obj_dir/Vtb_cluster_periph

.PHONY: all run clean

all: run

$(SIM): vlog.f $(shell cat vlog.f)
	verilator --binary --timing --assert --top-module tb_cluster_periph \
	  -f vlog.f -o Vtb_cluster_periph

# the verdict comes from the simulation log
run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
